/* filelist.f */
rtl/mem_types_pkg.sv
rtl/load_extender.sv
rtl/mem_stage.sv
rtl/instr_fetch.sv
rtl/bus_arbiter.sv
rtl/data_ram.sv
rtl/mem_subsys_top.sv
verification/mem_subsys_sva.sv
verification/mem_subsys_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG="$BUILD_DIR/sim.log"

if ! mkdir -p "$BUILD_DIR"; then
    echo "Could not create $BUILD_DIR"
    exit 1
fi

if ! verilator --binary --timing --assert -j 0 --top-module mem_subsys_tb \
        -Mdir "$BUILD_DIR/obj_dir" -o mem_subsys_sim -f filelist.f; then
    echo "Verilator build failed"
    exit 1
fi

"$BUILD_DIR/obj_dir/mem_subsys_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
if grep -q "Test failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Test passed" "$LOG"; then
    echo "Simulation log has no result line"
    exit 1
fi
exit 0

/* verification/mem_subsys_tb.sv */
`timescale 1ns/1ps

module mem_subsys_tb;

    import mem_types_pkg::*;

    localparam time               CLK_PERIOD  = 40ns;
    localparam time               DRIVE_DELAY = 2ns;
    localparam logic [ADDR_W-1:0] FETCH_BASE  = 32'h0000_0100;
    localparam int                FETCH_WORDS = 8;

    logic              CLK;
    logic              nRST;
    logic              ex_valid;
    ex_mem_t           ex_mem;
    logic              stall;
    wb_t               wb;
    logic              fetch_en;
    logic [ADDR_W-1:0] fetch_base;
    logic              fetch_out_valid;
    logic [ADDR_W-1:0] fetch_out_addr;
    logic [31:0]       fetch_out_word;

    logic [31:0]       ref_mem [MEM_WORDS];
    ex_mem_t           stim_q [$];
    wb_t               want_q [$];
    bit                data_chk_q [$];
    logic [ADDR_W-1:0] last_fetch;
    integer            seed;
    int                data_errs;
    int                fetch_errs;
    int                other_errs;
    int                fetch_count;
    bit                table_built;
    bit                preload_done;
    bit                data_done;

    mem_subsys_top dut (
        .CLK             (CLK),
        .nRST            (nRST),
        .ex_valid        (ex_valid),
        .ex_mem          (ex_mem),
        .stall           (stall),
        .wb              (wb),
        .fetch_en        (fetch_en),
        .fetch_base      (fetch_base),
        .fetch_out_valid (fetch_out_valid),
        .fetch_out_addr  (fetch_out_addr),
        .fetch_out_word  (fetch_out_word)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // Lanes touched by an access, little-endian
    function automatic logic [3:0] lanes_of(access_t acc, logic [1:0] off);
        logic [3:0] mask;
        case (acc)
            ACC_W:         mask = 4'hF;
            ACC_H, ACC_HU: mask = 4'h3;
            default:       mask = 4'h1;
        endcase
        return mask << off;
    endfunction

    function automatic bit is_misaligned(access_t acc, logic [1:0] off);
        case (acc)
            ACC_W:         return off != 2'd0;
            ACC_H, ACC_HU: return off[0];
            default:       return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] extend_load(logic [31:0] word, access_t acc,
                                                logic [1:0] off);
        logic [31:0] shifted;
        shifted = word >> (8 * off);
        case (acc)
            ACC_B:   return {{24{shifted[7]}}, shifted[7:0]};
            ACC_BU:  return {24'd0, shifted[7:0]};
            ACC_H:   return {{16{shifted[15]}}, shifted[15:0]};
            ACC_HU:  return {16'd0, shifted[15:0]};
            default: return word;
        endcase
    endfunction

    function automatic logic [31:0] merge_store(logic [31:0] old, logic [31:0] data,
                                                access_t acc, logic [1:0] off);
        logic [31:0] shifted;
        logic [31:0] result;
        logic [3:0]  lanes;
        shifted = data << (8 * off);
        lanes   = lanes_of(acc, off);
        result  = old;
        for (int b = 0; b < 4; b++) begin
            if (lanes[b]) begin
                result[8*b +: 8] = shifted[8*b +: 8];
            end
        end
        return result;
    endfunction

    // One table row, with its expected writeback from the reference memory
    task automatic add(logic dren, logic dwen, access_t acc, wsel_t wsel, logic [4:0] rd,
                       logic reg_write, logic [31:0] addr, logic [31:0] rs2);
        ex_mem_t            e;
        wb_t                want;
        logic [WORD_AW-1:0] idx;
        bit                 mal;
        e.dren      = dren;
        e.dwen      = dwen;
        e.acc       = acc;
        e.wsel      = wsel;
        e.rd        = rd;
        e.reg_write = reg_write;
        e.alu_out   = addr;
        e.rs2_data  = rs2;
        e.pc4       = 32'h0000_1000 + {25'd0, rd, 2'b00};
        e.imm_u     = {rs2[19:0], 12'h000};
        idx = addr[WORD_AW+1:2];
        mal = (dren || dwen) && is_misaligned(acc, addr[1:0]);
        want.valid     = 1'b1;
        want.rd        = rd;
        want.reg_write = reg_write;
        want.mal_load  = dren && mal;
        want.mal_store = dwen && mal;
        case (wsel)
            WB_LOAD: want.wdata = extend_load(ref_mem[idx], acc, addr[1:0]);
            WB_PC4:  want.wdata = e.pc4;
            WB_IMMU: want.wdata = e.imm_u;
            default: want.wdata = addr;
        endcase
        if (dwen && !mal) begin
            ref_mem[idx] = merge_store(ref_mem[idx], rs2, acc, addr[1:0]);
        end
        stim_q.push_back(e);
        want_q.push_back(want);
        data_chk_q.push_back(!(dren && mal));
    endtask

    task automatic build_table();
        logic [31:0] a;
        // Fetch region preload through the data port
        for (int k = 0; k < FETCH_WORDS; k++) begin
            a = FETCH_BASE + 32'(4 * k);
            add(1'b0, 1'b1, ACC_W, WB_ALU, 5'd0, 1'b0, a, (a * 32'h0001_0003) ^ 32'hA5C3_0F00);
        end
        add(1'b0, 1'b1, ACC_W,  WB_ALU,  5'd0,  1'b0, 32'h40, 32'h80F1_7F92);
        add(1'b1, 1'b0, ACC_W,  WB_LOAD, 5'd1,  1'b1, 32'h40, 32'h0);
        add(1'b1, 1'b0, ACC_H,  WB_LOAD, 5'd2,  1'b1, 32'h40, 32'h0);
        add(1'b1, 1'b0, ACC_H,  WB_LOAD, 5'd3,  1'b1, 32'h42, 32'h0);
        add(1'b1, 1'b0, ACC_HU, WB_LOAD, 5'd4,  1'b1, 32'h42, 32'h0);
        add(1'b1, 1'b0, ACC_B,  WB_LOAD, 5'd5,  1'b1, 32'h40, 32'h0);
        add(1'b1, 1'b0, ACC_BU, WB_LOAD, 5'd6,  1'b1, 32'h40, 32'h0);
        add(1'b1, 1'b0, ACC_B,  WB_LOAD, 5'd7,  1'b1, 32'h41, 32'h0);
        add(1'b1, 1'b0, ACC_B,  WB_LOAD, 5'd8,  1'b1, 32'h43, 32'h0);
        add(1'b1, 1'b0, ACC_BU, WB_LOAD, 5'd9,  1'b1, 32'h43, 32'h0);
        // Partial stores merging into one word
        add(1'b0, 1'b1, ACC_W,  WB_ALU,  5'd0,  1'b0, 32'h44, 32'h1122_3344);
        add(1'b0, 1'b1, ACC_B,  WB_ALU,  5'd0,  1'b0, 32'h45, 32'h1234_56AB);
        add(1'b0, 1'b1, ACC_HU, WB_ALU,  5'd0,  1'b0, 32'h46, 32'h7777_BEEF);
        add(1'b1, 1'b0, ACC_W,  WB_LOAD, 5'd10, 1'b1, 32'h44, 32'h0);
        // Misaligned, then confirm memory is untouched
        add(1'b0, 1'b1, ACC_H,  WB_ALU,  5'd0,  1'b0, 32'h41, 32'hDEAD_0000);
        add(1'b1, 1'b0, ACC_H,  WB_LOAD, 5'd11, 1'b1, 32'h43, 32'h0);
        add(1'b0, 1'b1, ACC_W,  WB_ALU,  5'd0,  1'b0, 32'h42, 32'hFFFF_FFFF);
        add(1'b1, 1'b0, ACC_W,  WB_LOAD, 5'd12, 1'b1, 32'h46, 32'h0);
        add(1'b1, 1'b0, ACC_W,  WB_LOAD, 5'd13, 1'b1, 32'h40, 32'h0);
        add(1'b1, 1'b0, ACC_W,  WB_LOAD, 5'd14, 1'b1, 32'h44, 32'h0);
        add(1'b0, 1'b0, ACC_W,  WB_PC4,  5'd15, 1'b1, 32'h0000_1234, 32'h0);
        add(1'b0, 1'b0, ACC_W,  WB_IMMU, 5'd16, 1'b1, 32'h0, 32'h000A_BCDE);
        add(1'b0, 1'b0, ACC_W,  WB_ALU,  5'd17, 1'b1, 32'hCAFE_F00D, 32'h0);
        add(1'b0, 1'b0, ACC_B,  WB_ALU,  5'd18, 1'b0, 32'h0000_0003, 32'h0);
        add(1'b0, 1'b1, ACC_W,  WB_ALU,  5'd0,  1'b0, 32'h48, 32'h0BAD_C0DE);
        add(1'b0, 1'b1, ACC_H,  WB_ALU,  5'd0,  1'b0, 32'h4A, 32'h0000_8001);
        add(1'b1, 1'b0, ACC_H,  WB_LOAD, 5'd19, 1'b1, 32'h4A, 32'h0);
        add(1'b1, 1'b0, ACC_BU, WB_LOAD, 5'd20, 1'b1, 32'h48, 32'h0);
        add(1'b1, 1'b0, ACC_W,  WB_LOAD, 5'd21, 1'b1, 32'h48, 32'h0);
    endtask

    task automatic apply_entry(int i);
        wb_t     want;
        ex_mem_t e;
        bit      ok;
        bit      mem_ok;
        bit      stall_ok;
        want     = want_q[i];
        e        = stim_q[i];
        ex_mem   = e;
        ex_valid = 1'b1;
        mem_ok   = (e.dren || e.dwen) && !is_misaligned(e.acc, e.alu_out[1:0]);
        @(negedge CLK);
        // Aligned loads always wait, register-only entries never do
        if (mem_ok && e.dren) begin
            stall_ok = (stall === 1'b1);
        end else begin
            stall_ok = mem_ok || (stall === 1'b0);
        end
        assert (stall_ok) else begin
            $display("ERR %0t: entry %0d stall %b in its first cycle", $time, i, stall);
            data_errs++;
        end
        while (stall) begin
            @(negedge CLK);
        end
        ok = (wb.valid === 1'b1) && (wb.rd === want.rd) && (wb.reg_write === want.reg_write)
             && (wb.mal_load === want.mal_load) && (wb.mal_store === want.mal_store)
             && (!data_chk_q[i] || (wb.wdata === want.wdata));
        assert (ok) else begin
            $display("ERR %0t: entry %0d writeback %h, expected %h", $time, i, wb, want);
            data_errs++;
        end
        @(posedge CLK);
        #DRIVE_DELAY;
    endtask

    task automatic check_fetch();
        bit ok_addr;
        bit ok_word;
        ok_addr = (fetch_out_addr == fetch_base) || (fetch_out_addr == last_fetch + 32'd4);
        ok_word = !$isunknown(fetch_out_word)
                  && (fetch_out_word == ref_mem[fetch_out_addr[WORD_AW+1:2]]);
        assert (ok_addr) else begin
            $display("ERR %0t: fetch address %h after %h", $time, fetch_out_addr, last_fetch);
            fetch_errs++;
        end
        assert (ok_word) else begin
            $display("ERR %0t: fetch word %h at %h, expected %h", $time, fetch_out_word,
                     fetch_out_addr, ref_mem[fetch_out_addr[WORD_AW+1:2]]);
            fetch_errs++;
        end
        last_fetch = fetch_out_addr;
        fetch_count++;
    endtask

    // Enable bursts of at most four cycles keep fetches inside the preload
    task automatic toggle_fetch();
        int hold;
        wait (preload_done);
        while (!data_done) begin
            hold = ($random(seed) & 3) + 1;
            repeat (hold) @(posedge CLK);
            #DRIVE_DELAY;
            fetch_en = !fetch_en;
        end
        fetch_en = 1'b0;
    endtask

    initial begin
        toggle_fetch();
    end

    initial begin
        forever begin
            @(negedge CLK);
            if (nRST && fetch_out_valid) begin
                check_fetch();
            end
        end
    end

    initial begin
        wait (table_built);
        #(CLK_PERIOD * (40 * stim_q.size() + 200));
        $display("Timeout: the run did not finish in the expected number of cycles");
        $display("Test failed");
        $finish;
    end

    initial begin
        nRST         = 1'b0;
        ex_valid     = 1'b0;
        ex_mem       = '0;
        fetch_en     = 1'b0;
        fetch_base   = FETCH_BASE;
        last_fetch   = '0;
        seed         = 68;
        data_errs    = 0;
        fetch_errs   = 0;
        other_errs   = 0;
        fetch_count  = 0;
        preload_done = 1'b0;
        data_done    = 1'b0;
        build_table();
        table_built = 1'b1;
        repeat (3) @(posedge CLK);
        #DRIVE_DELAY;
        assert (!stall && !wb.valid && !fetch_out_valid
                && dut.u_mem_stage.credits == credit_t'(REQ_CREDITS)
                && dut.u_instr_fetch.credits == credit_t'(REQ_CREDITS)) else begin
            $display("ERR %0t: outputs or credit counts wrong during reset", $time);
            other_errs++;
        end
        nRST = 1'b1;
        @(posedge CLK);
        #DRIVE_DELAY;
        for (int i = 0; i < stim_q.size(); i++) begin
            if (i == FETCH_WORDS) begin
                preload_done = 1'b1;
            end
            apply_entry(i);
        end
        ex_valid  = 1'b0;
        data_done = 1'b1;
        // Drain the fetches still in flight
        do begin
            @(negedge CLK);
        end while (fetch_en || dut.u_instr_fetch.credits != credit_t'(REQ_CREDITS)
                   || dut.u_bus_arbiter.rsp_pending);
        assert (fetch_count > 0) else begin
            $display("No fetched instruction word was seen during the data traffic");
            other_errs++;
        end
        $display("Errors: data %0d, fetch %0d, other %0d (%0d words fetched)",
                 data_errs, fetch_errs, other_errs, fetch_count);
        if (data_errs + fetch_errs + other_errs == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* verification/mem_subsys_sva.sv */
`timescale 1ns/1ps

module mem_subsys_sva (
    input logic                                CLK,
    input logic                                nRST,
    input logic [mem_types_pkg::NUM_PORTS-1:0] req_valid,
    input logic [mem_types_pkg::NUM_PORTS-1:0] credit_ret,
    input mem_types_pkg::credit_t              data_count,
    input mem_types_pkg::credit_t              fetch_count,
    input logic                                mem_valid,
    input mem_types_pkg::bus_req_t             mem_req,
    input mem_types_pkg::bus_rsp_t             rsp
);

    import mem_types_pkg::*;

    // A full queue never sees a new request
    a_no_overflow: assert property (@(posedge CLK) disable iff (!nRST)
        !(req_valid[PORT_DATA] && data_count == credit_t'(REQ_CREDITS))
        && !(req_valid[PORT_FETCH] && fetch_count == credit_t'(REQ_CREDITS)))
        else $error("request arrived at a full arbiter queue");

    // One credit per forward, to the port that issued the request
    a_one_credit: assert property (@(posedge CLK) disable iff (!nRST)
        credit_ret == (mem_valid ? (NUM_PORTS'(1) << mem_req.port) : NUM_PORTS'(0)))
        else $error("credit return does not match the forwarded request");

    // Read data one cycle after the forward, tagged with its port
    a_rsp_timing: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_valid && mem_req.ren) |=> (rsp.valid && rsp.port == $past(mem_req.port)))
        else $error("response not exactly one cycle after a read forward");

    a_reset_idle: assert property (@(posedge CLK) !nRST |-> !mem_valid)
        else $error("memory request during reset");

endmodule

bind bus_arbiter mem_subsys_sva u_arb_sva (
    .CLK         (CLK),
    .nRST        (nRST),
    .req_valid   (req_valid),
    .credit_ret  (credit_ret),
    .data_count  (count[mem_types_pkg::PORT_DATA]),
    .fetch_count (count[mem_types_pkg::PORT_FETCH]),
    .mem_valid   (mem_valid),
    .mem_req     (mem_req),
    .rsp         (rsp)
);

/* rtl/mem_subsys_top.sv */
`timescale 1ns/1ps

module mem_subsys_top (
    input  logic                             CLK,
    input  logic                             nRST,
    input  logic                             ex_valid,
    input  mem_types_pkg::ex_mem_t           ex_mem,
    output logic                             stall,
    output mem_types_pkg::wb_t               wb,
    input  logic                             fetch_en,
    input  logic [mem_types_pkg::ADDR_W-1:0] fetch_base,
    output logic                             fetch_out_valid,
    output logic [mem_types_pkg::ADDR_W-1:0] fetch_out_addr,
    output logic [31:0]                      fetch_out_word
);

    import mem_types_pkg::*;

    bus_req_t             port_req [NUM_PORTS];
    logic [NUM_PORTS-1:0] port_valid;
    logic [NUM_PORTS-1:0] port_credit;
    bus_rsp_t             rsp;
    logic                 mem_valid;
    bus_req_t             mem_req;
    logic [31:0]          mem_rdata;

    mem_stage u_mem_stage (
        .CLK        (CLK),
        .nRST       (nRST),
        .ex_valid   (ex_valid),
        .ex_mem     (ex_mem),
        .stall      (stall),
        .req_valid  (port_valid[PORT_DATA]),
        .req        (port_req[PORT_DATA]),
        .credit_ret (port_credit[PORT_DATA]),
        .rsp        (rsp),
        .wb         (wb)
    );

    instr_fetch u_instr_fetch (
        .CLK             (CLK),
        .nRST            (nRST),
        .fetch_en        (fetch_en),
        .fetch_base      (fetch_base),
        .req_valid       (port_valid[PORT_FETCH]),
        .req             (port_req[PORT_FETCH]),
        .credit_ret      (port_credit[PORT_FETCH]),
        .rsp             (rsp),
        .fetch_out_valid (fetch_out_valid),
        .fetch_out_addr  (fetch_out_addr),
        .fetch_out_word  (fetch_out_word)
    );

    bus_arbiter u_bus_arbiter (
        .CLK        (CLK),
        .nRST       (nRST),
        .req_valid  (port_valid),
        .req        (port_req),
        .credit_ret (port_credit),
        .mem_valid  (mem_valid),
        .mem_req    (mem_req),
        .mem_rdata  (mem_rdata),
        .rsp        (rsp)
    );

    data_ram u_data_ram (
        .CLK       (CLK),
        .mem_valid (mem_valid),
        .mem_req   (mem_req),
        .rdata     (mem_rdata)
    );

endmodule

/* rtl/data_ram.sv */
`timescale 1ns/1ps

module data_ram (
    input  logic                    CLK,
    input  logic                    mem_valid,
    input  mem_types_pkg::bus_req_t mem_req,
    output logic [31:0]             rdata
);

    import mem_types_pkg::*;

    logic [31:0] mem [MEM_WORDS];

    always_ff @(posedge CLK) begin
        // Only enabled lanes change
        if (mem_valid && mem_req.wen) begin
            for (int b = 0; b < 4; b++) begin
                if (mem_req.byte_en[b]) begin
                    mem[mem_req.word_addr][8*b +: 8] <= mem_req.wdata[8*b +: 8];
                end
            end
        end
        if (mem_valid && mem_req.ren) begin
            rdata <= mem[mem_req.word_addr];
        end
    end

endmodule

/* rtl/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter (
    input  logic                                CLK,
    input  logic                                nRST,
    input  logic [mem_types_pkg::NUM_PORTS-1:0] req_valid,
    input  mem_types_pkg::bus_req_t             req [mem_types_pkg::NUM_PORTS],
    output logic [mem_types_pkg::NUM_PORTS-1:0] credit_ret,
    output logic                                mem_valid,
    output mem_types_pkg::bus_req_t             mem_req,
    input  logic [31:0]                         mem_rdata,
    output mem_types_pkg::bus_rsp_t             rsp
);

    import mem_types_pkg::*;

    bus_req_t             slot   [NUM_PORTS][REQ_CREDITS];
    logic [QPTR_W-1:0]    wr_ptr [NUM_PORTS];
    logic [QPTR_W-1:0]    rd_ptr [NUM_PORTS];
    credit_t              count  [NUM_PORTS];
    logic [NUM_PORTS-1:0] not_empty;
    logic                 rr_next;
    logic                 grant;
    logic                 rsp_pending;
    logic                 rsp_port;

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            not_empty[p] = (count[p] != '0);
        end
    end

    // Alternate only when both queues hold work
    always_comb begin
        if (&not_empty) begin
            grant = rr_next;
        end else begin
            grant = not_empty[PORT_FETCH] ? PORT_FETCH : PORT_DATA;
        end
    end

    assign mem_valid = |not_empty;
    assign mem_req   = slot[grant][rd_ptr[grant]];

    // Credit goes back as the slot drains
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            credit_ret[p] = mem_valid && (int'(grant) == p);
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                wr_ptr[p] <= '0;
                rd_ptr[p] <= '0;
                count[p]  <= '0;
            end
            rr_next     <= PORT_DATA;
            rsp_pending <= 1'b0;
            rsp_port    <= PORT_DATA;
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (req_valid[p]) begin
                    wr_ptr[p] <= wr_ptr[p] + 1'b1;
                end
                if (credit_ret[p]) begin
                    rd_ptr[p] <= rd_ptr[p] + 1'b1;
                end
                case ({req_valid[p], credit_ret[p]})
                    2'b10:   count[p] <= count[p] + 1'b1;
                    2'b01:   count[p] <= count[p] - 1'b1;
                    default: count[p] <= count[p];
                endcase
            end
            if (mem_valid) begin
                rr_next <= !grant;
            end
            // Tag for next cycle's read data
            rsp_pending <= mem_valid && mem_req.ren;
            rsp_port    <= grant;
        end
    end

    always_ff @(posedge CLK) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (req_valid[p]) begin
                slot[p][wr_ptr[p]] <= req[p];
            end
        end
    end

    assign rsp.valid = rsp_pending;
    assign rsp.port  = rsp_port;
    assign rsp.rdata = mem_rdata;

endmodule

/* rtl/instr_fetch.sv */
`timescale 1ns/1ps

module instr_fetch (
    input  logic                             CLK,
    input  logic                             nRST,
    input  logic                             fetch_en,
    input  logic [mem_types_pkg::ADDR_W-1:0] fetch_base,
    output logic                             req_valid,
    output mem_types_pkg::bus_req_t          req,
    input  logic                             credit_ret,
    input  mem_types_pkg::bus_rsp_t          rsp,
    output logic                             fetch_out_valid,
    output logic [mem_types_pkg::ADDR_W-1:0] fetch_out_addr,
    output logic [31:0]                      fetch_out_word
);

    import mem_types_pkg::*;

    logic [ADDR_W-1:0] fetch_pc;
    logic [ADDR_W-1:0] issue_pc;
    logic [ADDR_W-1:0] addr_q [2];
    logic              fetch_en_q;
    logic              en_rise;
    logic              wr_ptr;
    logic              rd_ptr;
    logic              rsp_hit;
    credit_t           credits;

    // Restart from the base on each enable
    assign en_rise  = fetch_en && !fetch_en_q;
    assign issue_pc = en_rise ? fetch_base : fetch_pc;
    assign rsp_hit  = rsp.valid && (rsp.port == PORT_FETCH);

    assign req_valid     = fetch_en && (credits != '0);
    assign req.ren       = 1'b1;
    assign req.wen       = 1'b0;
    assign req.byte_en   = 4'b1111;
    assign req.word_addr = issue_pc[WORD_AW+1:2];
    assign req.wdata     = '0;
    assign req.port      = PORT_FETCH;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            fetch_en_q <= 1'b0;
            fetch_pc   <= '0;
            credits    <= credit_t'(REQ_CREDITS);
            wr_ptr     <= 1'b0;
            rd_ptr     <= 1'b0;
        end else begin
            fetch_en_q <= fetch_en;
            if (req_valid) begin
                fetch_pc <= issue_pc + ADDR_W'(4);
            end else if (en_rise) begin
                fetch_pc <= fetch_base;
            end
            case ({req_valid, credit_ret})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
            if (req_valid) begin
                wr_ptr <= !wr_ptr;
            end
            if (rsp_hit) begin
                rd_ptr <= !rd_ptr;
            end
        end
    end

    // Addresses of reads still in flight
    always_ff @(posedge CLK) begin
        if (req_valid) begin
            addr_q[wr_ptr] <= issue_pc;
        end
    end

    assign fetch_out_valid = rsp_hit;
    assign fetch_out_addr  = addr_q[rd_ptr];
    assign fetch_out_word  = rsp.rdata;

endmodule

/* rtl/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    ex_valid,
    input  mem_types_pkg::ex_mem_t  ex_mem,
    output logic                    stall,
    output logic                    req_valid,
    output mem_types_pkg::bus_req_t req,
    input  logic                    credit_ret,
    input  mem_types_pkg::bus_rsp_t rsp,
    output mem_types_pkg::wb_t      wb
);

    import mem_types_pkg::*;

    ms_state_t   state;
    ms_state_t   state_next;
    credit_t     credits;
    logic [1:0]  byte_off;
    logic [3:0]  byte_en;
    logic [31:0] store_data;
    logic [31:0] load_data;
    logic [31:0] wb_value;
    logic        mal_addr;
    logic        mem_op;
    logic        has_credit;
    logic        load_done;

    assign byte_off   = ex_mem.alu_out[1:0];
    assign mem_op     = ex_mem.dren || ex_mem.dwen;
    assign has_credit = (credits != '0);
    assign load_done  = rsp.valid && (rsp.port == PORT_DATA);

    // Lane enables from width and offset
    always_comb begin
        case (ex_mem.acc)
            ACC_B, ACC_BU: byte_en = 4'b0001 << byte_off;
            ACC_H, ACC_HU: byte_en = byte_off[1] ? 4'b1100 : 4'b0011;
            ACC_W:         byte_en = 4'b1111;
            default:       byte_en = 4'b0000;
        endcase
    end

    // Halfwords need even addresses, words need word addresses
    always_comb begin
        case (ex_mem.acc)
            ACC_H, ACC_HU: mal_addr = byte_off[0];
            ACC_W:         mal_addr = (byte_off != 2'b00);
            default:       mal_addr = 1'b0;
        endcase
    end

    // Store data repeated on every lane
    always_comb begin
        case (ex_mem.acc)
            ACC_B, ACC_BU: store_data = {4{ex_mem.rs2_data[7:0]}};
            ACC_H, ACC_HU: store_data = {2{ex_mem.rs2_data[15:0]}};
            default:       store_data = ex_mem.rs2_data;
        endcase
    end

    assign req_valid = ex_valid && (state == MS_IDLE) && mem_op && !mal_addr && has_credit;

    assign req.ren       = ex_mem.dren;
    assign req.wen       = ex_mem.dwen;
    assign req.byte_en   = byte_en;
    assign req.word_addr = ex_mem.alu_out[WORD_AW+1:2];
    assign req.wdata     = store_data;
    assign req.port      = PORT_DATA;

    // Loads hold until their response, stores only until a credit
    always_comb begin
        stall = 1'b0;
        if (ex_valid && mem_op && !mal_addr) begin
            if (state == MS_WAIT_LOAD) begin
                stall = !load_done;
            end else begin
                stall = ex_mem.dren || !has_credit;
            end
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            MS_IDLE: begin
                if (req_valid && ex_mem.dren) begin
                    state_next = MS_WAIT_LOAD;
                end
            end
            MS_WAIT_LOAD: begin
                if (load_done) begin
                    state_next = MS_IDLE;
                end
            end
            default: state_next = MS_IDLE;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state   <= MS_IDLE;
            credits <= credit_t'(REQ_CREDITS);
        end else begin
            state <= state_next;
            case ({req_valid, credit_ret})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    load_extender u_load_ext (
        .rdata    (rsp.rdata),
        .acc      (ex_mem.acc),
        .byte_off (byte_off),
        .ext_out  (load_data)
    );

    always_comb begin
        case (ex_mem.wsel)
            WB_LOAD: wb_value = load_data;
            WB_PC4:  wb_value = ex_mem.pc4;
            WB_IMMU: wb_value = ex_mem.imm_u;
            default: wb_value = ex_mem.alu_out;
        endcase
    end

    // Completion is the accepting edge
    assign wb.valid     = ex_valid && !stall;
    assign wb.rd        = ex_mem.rd;
    assign wb.reg_write = ex_mem.reg_write;
    assign wb.wdata     = wb_value;
    assign wb.mal_load  = ex_mem.dren && mal_addr;
    assign wb.mal_store = ex_mem.dwen && mal_addr;

endmodule

/* rtl/load_extender.sv */
`timescale 1ns/1ps

module load_extender (
    input  logic [31:0]            rdata,
    input  mem_types_pkg::access_t acc,
    input  logic [1:0]             byte_off,
    output logic [31:0]            ext_out
);

    import mem_types_pkg::*;

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    // Little-endian lane pick
    always_comb begin
        sel_byte = rdata[{byte_off, 3'b000} +: 8];
        sel_half = byte_off[1] ? rdata[31:16] : rdata[15:0];
    end

    always_comb begin
        case (acc)
            ACC_B:   ext_out = {{24{sel_byte[7]}}, sel_byte};
            ACC_BU:  ext_out = {24'h000000, sel_byte};
            ACC_H:   ext_out = {{16{sel_half[15]}}, sel_half};
            ACC_HU:  ext_out = {16'h0000, sel_half};
            default: ext_out = rdata;
        endcase
    end

endmodule

/* rtl/mem_types_pkg.sv */
package mem_types_pkg;

    localparam int ADDR_W      = 32;
    localparam int MEM_WORDS   = 256;
    localparam int REQ_CREDITS = 2;
    localparam int NUM_PORTS   = 2;

    // Derived widths
    localparam int WORD_AW  = $clog2(MEM_WORDS);
    localparam int CREDIT_W = $clog2(REQ_CREDITS + 1);
    localparam int QPTR_W   = $clog2(REQ_CREDITS);

    localparam logic PORT_DATA  = 1'b0;
    localparam logic PORT_FETCH = 1'b1;

    typedef logic [CREDIT_W-1:0] credit_t;

    // Load/store width and signedness
    typedef enum logic [2:0] {
        ACC_B  = 3'd0,
        ACC_BU = 3'd1,
        ACC_H  = 3'd2,
        ACC_HU = 3'd3,
        ACC_W  = 3'd4
    } access_t;

    typedef enum logic [1:0] {
        WB_LOAD = 2'd0,
        WB_PC4  = 2'd1,
        WB_IMMU = 2'd2,
        WB_ALU  = 2'd3
    } wsel_t;

    typedef enum logic {
        MS_IDLE      = 1'b0,
        MS_WAIT_LOAD = 1'b1
    } ms_state_t;

    typedef struct packed {
        logic              dren;
        logic              dwen;
        access_t           acc;
        wsel_t             wsel;
        logic [4:0]        rd;
        logic              reg_write;
        logic [ADDR_W-1:0] alu_out;
        logic [31:0]       rs2_data;
        logic [31:0]       pc4;
        logic [31:0]       imm_u;
    } ex_mem_t;

    typedef struct packed {
        logic               ren;
        logic               wen;
        logic [3:0]         byte_en;
        logic [WORD_AW-1:0] word_addr;
        logic [31:0]        wdata;
        logic               port;
    } bus_req_t;

    typedef struct packed {
        logic        valid;
        logic        port;
        logic [31:0] rdata;
    } bus_rsp_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic        reg_write;
        logic [31:0] wdata;
        logic        mal_load;
        logic        mal_store;
    } wb_t;

endpackage
